//--- rtl/cache_config.svh
/*
 * cache geometry and bus widths for the blocking cache
 * 256 bytes held as 16 lines of four 32-bit words
 */

`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// ==============================
// bus widths
// ==============================
`define CACHE_ADDR_BITS 32
`define CACHE_DATA_BITS 32

// ==============================
// line geometry
// ==============================
`define CACHE_LINE_BITS 128
`define CACHE_NUM_LINES 16
`define CACHE_WORDS_PER_LINE 4

// the tag keeps every address bit above the byte offset
`define CACHE_INDEX_BITS 4
`define CACHE_OFFSET_BITS 4
`define CACHE_TAG_BITS 28

`endif

//--- rtl/mem_msg_pkg.sv
/*
 * message types on the processor side and the memory side of the cache
 */

`include "cache_config.svh"

package mem_msg_pkg;

  // request and response operations, shared by both sides
  typedef enum logic [1:0] {
    op_read  = 2'd0,
    op_write = 2'd1,
    op_init  = 2'd2
  } mem_op_e;

  // processor request, always a full word
  typedef struct packed {
    mem_op_e                     op;
    logic [`CACHE_ADDR_BITS-1:0] addr;
    logic [`CACHE_DATA_BITS-1:0] data;
  } cache_req_t;

  // processor response, the data field only carries meaning for reads
  typedef struct packed {
    mem_op_e                     op;
    logic                        hit;
    logic [`CACHE_DATA_BITS-1:0] data;
  } cache_resp_t;

  // memory request, the address is always line aligned
  typedef struct packed {
    mem_op_e                     op;
    logic [`CACHE_ADDR_BITS-1:0] addr;
    logic [`CACHE_LINE_BITS-1:0] data;
  } mem_req_t;

  // memory response, a whole line on reads and an acknowledge on writes
  typedef struct packed {
    mem_op_e                     op;
    logic [`CACHE_LINE_BITS-1:0] data;
  } mem_resp_t;

endpackage

//--- rtl/cache_pkg.sv
/*
 * cache internal types: controller states, request fields, storage controls
 */

`include "cache_config.svh"

package cache_pkg;

  typedef enum logic [3:0] {
    state_idle,
    state_tag_check,
    state_init_access,
    state_read_access,
    state_write_access,
    state_evict_prepare,
    state_evict_request,
    state_evict_wait,
    state_refill_request,
    state_refill_wait,
    state_refill_update,
    state_respond
  } cache_state_e;

  // captured request with the address already split into its fields
  // the tag overlaps the index, since it holds every bit above the offset
  typedef struct packed {
    mem_msg_pkg::mem_op_e                      op;
    logic [`CACHE_TAG_BITS-1:0]                tag;
    logic [`CACHE_INDEX_BITS-1:0]              index;
    logic [$clog2(`CACHE_WORDS_PER_LINE)-1:0]  word_sel;
    logic [`CACHE_DATA_BITS-1:0]               data;
  } req_fields_t;

  // strobes from the controller to the storage and the output side
  typedef struct packed {
    logic tag_read;
    logic tag_write;
    logic data_read;
    logic line_write;
    logic word_write;
    logic fill_from_memory;
    logic capture_evict;
    logic capture_read;
    logic memreq_is_evict;
  } store_ctrl_t;

endpackage

//--- rtl/cache_req_in.sv
/*
 * request capture that holds the accepted processor request and splits its
 * address into tag, index and word select
 */

`timescale 1ns/1ps

`include "cache_config.svh"

module cache_req_in (
  input  logic                    clk,
  input  logic                    reset,
  input  mem_msg_pkg::cache_req_t cachereq,
  input  logic                    cachereq_val,
  input  logic                    accept,
  output cache_pkg::req_fields_t  fields
);

  localparam int word_sel_bits = $clog2(`CACHE_WORDS_PER_LINE);

  // the fields stay put for the whole life of a request, since accept only
  // fires from idle and the controller stays out of idle until the response
  always_ff @(posedge clk) begin
    if (accept) begin
      fields.op    <= cachereq.op;
      fields.data  <= cachereq.data;
      // every bit above the byte offset goes into the tag
      fields.tag   <= cachereq.addr[`CACHE_ADDR_BITS-1:`CACHE_OFFSET_BITS];
      fields.index <= cachereq.addr[`CACHE_OFFSET_BITS+`CACHE_INDEX_BITS-1:
                                    `CACHE_OFFSET_BITS];
      // word select drops the two byte bits inside a word
      fields.word_sel <= cachereq.addr[`CACHE_OFFSET_BITS-1:
                                       `CACHE_OFFSET_BITS-word_sel_bits];
    end
  end

  // ==============================
  // checks
  // ==============================

  // the processor holds its request steady until the cache takes it
  assert property (@(posedge clk) disable iff (reset)
    cachereq_val && !accept |=> cachereq_val && $stable(cachereq))
  else $error("cachereq changed before it was accepted");

  // a captured op must be known and one of the three legal operations
  assert property (@(posedge clk) disable iff (reset)
    accept |-> !$isunknown(cachereq.op) &&
      (cachereq.op inside {mem_msg_pkg::op_read, mem_msg_pkg::op_write,
                           mem_msg_pkg::op_init}))
  else $error("unknown op captured: %b", cachereq.op);

endmodule

//--- rtl/cache_ctrl.sv
/*
 * cache controller: the request FSM plus the per-line valid and dirty bits
 * it picks init, hit access, eviction then refill, or refill alone
 */

`timescale 1ns/1ps

`include "cache_config.svh"

module cache_ctrl (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   cachereq_val,
  output logic                   cachereq_rdy,
  output logic                   accept,
  input  cache_pkg::req_fields_t fields,
  input  logic                   tag_match,
  output logic                   hit,
  output cache_pkg::store_ctrl_t ctrl,
  output logic                   memreq_val,
  input  logic                   memreq_rdy,
  input  logic                   memresp_val,
  output logic                   memresp_rdy,
  output logic                   cacheresp_val,
  input  logic                   cacheresp_rdy
);

  cache_pkg::cache_state_e state;
  cache_pkg::cache_state_e state_next;

  logic [`CACHE_NUM_LINES-1:0] valid_bits;
  logic [`CACHE_NUM_LINES-1:0] dirty_bits;
  logic                        line_dirty;
  // a whole line was written, so the line becomes valid and clean
  logic                        mark_filled;
  // a word was written into a present line
  logic                        mark_dirty;

  // tag_match is only live during tag_check, so hit is too
  assign hit        = valid_bits[fields.index] && tag_match;
  assign line_dirty = valid_bits[fields.index] && dirty_bits[fields.index];

  // handshake outputs come straight from the state
  assign cachereq_rdy  = (state == cache_pkg::state_idle);
  assign accept        = cachereq_rdy && cachereq_val;
  assign memreq_val    = (state == cache_pkg::state_evict_request) ||
                         (state == cache_pkg::state_refill_request);
  assign memresp_rdy   = (state == cache_pkg::state_evict_wait) ||
                         (state == cache_pkg::state_refill_wait);
  assign cacheresp_val = (state == cache_pkg::state_respond);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= cache_pkg::state_idle;
    end else begin
      state <= state_next;
    end
  end

  // ==============================
  // next state and strobes
  // ==============================
  always_comb begin
    state_next  = state;
    ctrl        = '0;
    mark_filled = 1'b0;
    mark_dirty  = 1'b0;
    case (state)
      cache_pkg::state_idle: begin
        if (cachereq_val) state_next = cache_pkg::state_tag_check;
      end
      // the line read starts here too, so a read hit has it one cycle later
      cache_pkg::state_tag_check: begin
        ctrl.tag_read  = 1'b1;
        ctrl.data_read = 1'b1;
        if (fields.op == mem_msg_pkg::op_init) begin
          state_next = cache_pkg::state_init_access;
        end else if (hit && fields.op == mem_msg_pkg::op_read) begin
          state_next = cache_pkg::state_read_access;
        end else if (hit) begin
          state_next = cache_pkg::state_write_access;
        end else if (line_dirty) begin
          state_next = cache_pkg::state_evict_prepare;
        end else begin
          state_next = cache_pkg::state_refill_request;
        end
      end
      // init overwrites the line whatever the tag check found
      cache_pkg::state_init_access: begin
        ctrl.line_write = 1'b1;
        ctrl.tag_write  = 1'b1;
        mark_filled     = 1'b1;
        state_next      = cache_pkg::state_respond;
      end
      cache_pkg::state_read_access: begin
        ctrl.capture_read = 1'b1;
        state_next        = cache_pkg::state_respond;
      end
      cache_pkg::state_write_access: begin
        ctrl.word_write = 1'b1;
        mark_dirty      = 1'b1;
        state_next      = cache_pkg::state_respond;
      end
      // latch the old tag and line before anything overwrites them
      cache_pkg::state_evict_prepare: begin
        ctrl.data_read     = 1'b1;
        ctrl.capture_evict = 1'b1;
        state_next         = cache_pkg::state_evict_request;
      end
      cache_pkg::state_evict_request: begin
        ctrl.memreq_is_evict = 1'b1;
        if (memreq_rdy) state_next = cache_pkg::state_evict_wait;
      end
      // the write-back acknowledge carries no data
      cache_pkg::state_evict_wait: begin
        if (memresp_val) state_next = cache_pkg::state_refill_request;
      end
      cache_pkg::state_refill_request: begin
        if (memreq_rdy) state_next = cache_pkg::state_refill_wait;
      end
      // the refill line lands in the array on the transfer edge
      cache_pkg::state_refill_wait: begin
        if (memresp_val) begin
          ctrl.line_write       = 1'b1;
          ctrl.fill_from_memory = 1'b1;
          ctrl.tag_write        = 1'b1;
          mark_filled           = 1'b1;
          state_next            = cache_pkg::state_refill_update;
        end
      end
      // reload the registered line, then finish as a hit would
      cache_pkg::state_refill_update: begin
        ctrl.data_read = 1'b1;
        if (fields.op == mem_msg_pkg::op_read) begin
          state_next = cache_pkg::state_read_access;
        end else begin
          state_next = cache_pkg::state_write_access;
        end
      end
      // third cycle after acceptance on the hit path
      cache_pkg::state_respond: begin
        if (cacheresp_rdy) state_next = cache_pkg::state_idle;
      end
      default: state_next = cache_pkg::state_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else if (mark_filled) begin
      valid_bits[fields.index] <= 1'b1;
      dirty_bits[fields.index] <= 1'b0;
    end else if (mark_dirty) begin
      dirty_bits[fields.index] <= 1'b1;
    end
  end

  // a memory request is held until the memory takes it
  assert property (@(posedge clk) disable iff (reset)
    memreq_val && !memreq_rdy |=> memreq_val)
  else $error("memreq_val dropped without a transfer");

  // the cache never talks to the processor and the memory at once
  assert property (@(posedge clk) disable iff (reset)
    !(cacheresp_val && memreq_val))
  else $error("cacheresp_val and memreq_val high together");

endmodule

//--- rtl/cache_store.sv
/*
 * cache storage: tag and data arrays, tag compare, registered line read
 */

`timescale 1ns/1ps

`include "cache_config.svh"

module cache_store (
  input  logic                        clk,
  input  cache_pkg::req_fields_t      fields,
  input  cache_pkg::store_ctrl_t      ctrl,
  input  mem_msg_pkg::mem_resp_t      memresp,
  output logic                        tag_match,
  output logic [`CACHE_LINE_BITS-1:0] line,
  output logic [`CACHE_TAG_BITS-1:0]  evict_tag
);

  logic [`CACHE_TAG_BITS-1:0]  tag_array  [`CACHE_NUM_LINES];
  logic [`CACHE_LINE_BITS-1:0] data_array [`CACHE_NUM_LINES];

  logic [`CACHE_TAG_BITS-1:0]  stored_tag;
  logic [`CACHE_LINE_BITS-1:0] fill_line;

  // ==============================
  // tag side
  // ==============================

  assign stored_tag = tag_array[fields.index];

  // compare is only reported while the controller asks for it, so a stale
  // match in later states never reads as a hit
  assign tag_match = ctrl.tag_read && (stored_tag == fields.tag);

  always_ff @(posedge clk) begin
    if (ctrl.tag_write) begin
      tag_array[fields.index] <= fields.tag;
    end
  end

  // old tag for the write-back address, taken in evict_prepare
  always_ff @(posedge clk) begin
    if (ctrl.capture_evict) begin
      evict_tag <= stored_tag;
    end
  end

  // ==============================
  // data side
  // ==============================

  // a full line comes from memory on refill, or is the request word
  // copied into every slot on init
  assign fill_line = ctrl.fill_from_memory ? memresp.data
                                           : {`CACHE_WORDS_PER_LINE{fields.data}};

  always_ff @(posedge clk) begin
    if (ctrl.line_write) begin
      data_array[fields.index] <= fill_line;
    end else if (ctrl.word_write) begin
      data_array[fields.index][fields.word_sel*`CACHE_DATA_BITS +: `CACHE_DATA_BITS]
        <= fields.data;
    end
  end

  // the line register also holds the evicted line until the write-back
  // is taken, since nothing reads the array in between
  always_ff @(posedge clk) begin
    if (ctrl.data_read) begin
      line <= data_array[fields.index];
    end
  end

  // a full line write and a word write in one cycle would drop the word
  assert property (@(posedge clk)
    !(ctrl.line_write && ctrl.word_write))
  else $error("line_write and word_write high together");

endmodule

//--- rtl/cache_resp_out.sv
/*
 * output side: builds the memory request and the processor response
 */

`timescale 1ns/1ps

`include "cache_config.svh"

module cache_resp_out (
  input  logic                        clk,
  input  logic                        reset,
  input  cache_pkg::req_fields_t      fields,
  input  cache_pkg::store_ctrl_t      ctrl,
  input  logic                        hit,
  input  logic [`CACHE_LINE_BITS-1:0] line,
  input  logic [`CACHE_TAG_BITS-1:0]  evict_tag,
  output mem_msg_pkg::mem_req_t       memreq,
  output mem_msg_pkg::cache_resp_t    cacheresp
);

  logic                        hit_q;
  logic [`CACHE_DATA_BITS-1:0] word_q;

  // hit is only meaningful during tag_check, so sample it there
  always_ff @(posedge clk) begin
    if (reset) begin
      hit_q <= 1'b0;
    end else if (ctrl.tag_read) begin
      hit_q <= hit;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.capture_read) begin
      word_q <= line[fields.word_sel*`CACHE_DATA_BITS +: `CACHE_DATA_BITS];
    end
  end

  // the old tag already holds the index bits, so it alone gives the
  // write-back line address
  always_comb begin
    if (ctrl.memreq_is_evict) begin
      memreq.op   = mem_msg_pkg::op_write;
      memreq.addr = {evict_tag, {`CACHE_OFFSET_BITS{1'b0}}};
      memreq.data = line;
    end else begin
      memreq.op   = mem_msg_pkg::op_read;
      memreq.addr = {fields.tag, {`CACHE_OFFSET_BITS{1'b0}}};
      memreq.data = '0;
    end
  end

  // writes and inits answer with zero data
  assign cacheresp.op   = fields.op;
  assign cacheresp.hit  = hit_q;
  assign cacheresp.data = (fields.op == mem_msg_pkg::op_read) ? word_q : '0;

endmodule

//--- rtl/blocking_cache.sv
/*
 * blocking direct-mapped write-back cache, top level
 */

`timescale 1ns/1ps

`include "cache_config.svh"

module blocking_cache (
  input  logic                     clk,
  input  logic                     reset,
  // processor request
  input  mem_msg_pkg::cache_req_t  cachereq,
  input  logic                     cachereq_val,
  output logic                     cachereq_rdy,
  // processor response
  output mem_msg_pkg::cache_resp_t cacheresp,
  output logic                     cacheresp_val,
  input  logic                     cacheresp_rdy,
  // memory request
  output mem_msg_pkg::mem_req_t    memreq,
  output logic                     memreq_val,
  input  logic                     memreq_rdy,
  // memory response
  input  mem_msg_pkg::mem_resp_t   memresp,
  input  logic                     memresp_val,
  output logic                     memresp_rdy
);

  logic                        accept;
  cache_pkg::req_fields_t      fields;
  cache_pkg::store_ctrl_t      store_ctrl;
  logic                        tag_match;
  logic                        hit;
  logic [`CACHE_LINE_BITS-1:0] line;
  logic [`CACHE_TAG_BITS-1:0]  evict_tag;

  cache_req_in i_cache_req_in (
    .clk(clk), .reset(reset), .cachereq(cachereq), .cachereq_val(cachereq_val),
    .accept(accept), .fields(fields)
  );

  cache_ctrl i_cache_ctrl (
    .clk(clk), .reset(reset), .cachereq_val(cachereq_val), .cachereq_rdy(cachereq_rdy),
    .accept(accept), .fields(fields), .tag_match(tag_match), .hit(hit),
    .ctrl(store_ctrl), .memreq_val(memreq_val), .memreq_rdy(memreq_rdy),
    .memresp_val(memresp_val), .memresp_rdy(memresp_rdy),
    .cacheresp_val(cacheresp_val), .cacheresp_rdy(cacheresp_rdy)
  );

  cache_store i_cache_store (
    .clk(clk), .fields(fields), .ctrl(store_ctrl), .memresp(memresp),
    .tag_match(tag_match), .line(line), .evict_tag(evict_tag)
  );

  cache_resp_out i_cache_resp_out (
    .clk(clk), .reset(reset), .fields(fields), .ctrl(store_ctrl), .hit(hit),
    .line(line), .evict_tag(evict_tag), .memreq(memreq), .cacheresp(cacheresp)
  );

endmodule

//--- test/cache_tb.sv
/*
 * testbench for the blocking cache that runs random requests against a reference
 * model and serves memory requests after random delays
 */

`timescale 1ns/1ps

`include "cache_config.svh"

module cache_tb;

  localparam logic [31:0] seed = 32'h9d60_2b13;
  localparam int num_random = 400;
  localparam int num_directed = 16;
  // a dirty miss with the longest memory and response stalls stays well under 64 cycles
  localparam int watchdog_ns = (8 + (num_random + num_directed) * 64) * 20;

  logic                     clk;
  logic                     reset;
  mem_msg_pkg::cache_req_t  cachereq;
  logic                     cachereq_val;
  logic                     cachereq_rdy;
  mem_msg_pkg::cache_resp_t cacheresp;
  logic                     cacheresp_val;
  logic                     cacheresp_rdy;
  mem_msg_pkg::mem_req_t    memreq;
  logic                     memreq_val;
  logic                     memreq_rdy;
  mem_msg_pkg::mem_resp_t   memresp;
  logic                     memresp_val;
  logic                     memresp_rdy;

  // each stimulus process keeps its own random state
  logic [31:0] main_rng;
  logic [31:0] mem_rng;

  // backing store seen by the cache, and the word values a processor should read
  logic [31:0] backing_mem [logic [31:0]];
  logic [31:0] ref_mem     [logic [31:0]];
  logic [`CACHE_TAG_BITS-1:0] ref_tag [`CACHE_NUM_LINES];
  logic [`CACHE_NUM_LINES-1:0] ref_valid;
  logic [`CACHE_NUM_LINES-1:0] ref_dirty;
  // memory traffic that the current request has to produce, in order
  mem_msg_pkg::mem_req_t expected_mem [$];

  blocking_cache i_blocking_cache (
    .clk(clk), .reset(reset),
    .cachereq(cachereq), .cachereq_val(cachereq_val), .cachereq_rdy(cachereq_rdy),
    .cacheresp(cacheresp), .cacheresp_val(cacheresp_val), .cacheresp_rdy(cacheresp_rdy),
    .memreq(memreq), .memreq_val(memreq_val), .memreq_rdy(memreq_rdy),
    .memresp(memresp), .memresp_val(memresp_val), .memresp_rdy(memresp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ==============================
  // helpers
  // ==============================

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // untouched memory words mix every address bit
  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
  endfunction

  function automatic logic [31:0] backing_word(input logic [31:0] a);
    return backing_mem.exists(a) ? backing_mem[a] : fill_word(a);
  endfunction

  function automatic logic [31:0] ref_word(input logic [31:0] a);
    return ref_mem.exists(a) ? ref_mem[a] : fill_word(a);
  endfunction

  // three tags over four indexes, so lines collide often
  function automatic logic [31:0] pick_addr(input logic [31:0] r);
    logic [23:0] upper;
    case (r[9:8])
      2'd0:    upper = 24'h000010;
      2'd1:    upper = 24'h0004a2;
      default: upper = 24'h0fe003;
    endcase
    return {upper, r[3:2], 2'b01, r[5:4], 2'b00};
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("** FAIL **");
    $fatal(1, "simulation stopped");
  endtask

  task automatic compare_value(input string name, input logic [161:0] got,
                               input logic [161:0] expected);
    if (got !== expected) begin
      $display("[ERROR] time %0t, %s: got 'h%0h, expected 'h%0h",
               $time, name, got, expected);
      abort_run("value mismatch");
    end
  endtask

  // ==============================
  // reference model
  // ==============================

  // updates the model for one request and queues the memory traffic it implies
  task automatic model_request(input mem_msg_pkg::mem_op_e op, input logic [31:0] addr,
                               input logic [31:0] data,
                               output mem_msg_pkg::cache_resp_t expected);
    logic [3:0]   idx;
    logic [27:0]  tag;
    logic [31:0]  line_base;
    logic [31:0]  old_base;
    logic         hit;
    mem_msg_pkg::mem_req_t traffic;
    idx       = addr[7:4];
    tag       = addr[31:4];
    line_base = {tag, 4'h0};
    old_base  = {ref_tag[idx], 4'h0};
    hit       = ref_valid[idx] && (ref_tag[idx] == tag);
    expected.op   = op;
    expected.hit  = hit;
    expected.data = '0;
    if (op == mem_msg_pkg::op_init) begin
      // init drops a dirty line of another tag, so memory holds its words again
      if (ref_valid[idx] && ref_dirty[idx] && !hit) begin
        for (int k = 0; k < 4; k++) ref_mem[old_base + 4 * k] = backing_word(old_base + 4 * k);
      end
      // memory gets the init word too, so it never disagrees with the line
      for (int k = 0; k < 4; k++) begin
        backing_mem[line_base + 4 * k] = data;
        ref_mem[line_base + 4 * k]     = data;
      end
      ref_tag[idx]   = tag;
      ref_valid[idx] = 1'b1;
      ref_dirty[idx] = 1'b0;
    end else begin
      if (!hit) begin
        if (ref_valid[idx] && ref_dirty[idx]) begin
          traffic.op   = mem_msg_pkg::op_write;
          traffic.addr = old_base;
          for (int k = 0; k < 4; k++) traffic.data[k * 32 +: 32] = ref_word(old_base + 4 * k);
          expected_mem.push_back(traffic);
        end
        traffic.op   = mem_msg_pkg::op_read;
        traffic.addr = line_base;
        traffic.data = '0;
        expected_mem.push_back(traffic);
        ref_tag[idx]   = tag;
        ref_valid[idx] = 1'b1;
        ref_dirty[idx] = 1'b0;
      end
      if (op == mem_msg_pkg::op_read) begin
        expected.data = ref_word(addr);
      end else begin
        ref_mem[addr]  = data;
        ref_dirty[idx] = 1'b1;
      end
    end
  endtask

  // ==============================
  // processor side
  // ==============================

  task automatic run_request(input mem_msg_pkg::mem_op_e op, input logic [31:0] addr,
                             input logic [31:0] data);
    mem_msg_pkg::cache_req_t  req;
    mem_msg_pkg::cache_resp_t expected;
    mem_msg_pkg::cache_resp_t held;
    int                       stall;
    int                       cycles;
    logic                     expect_fast;
    model_request(op, addr, data, expected);
    expect_fast = (op == mem_msg_pkg::op_init) || expected.hit;
    main_rng = xorshift(main_rng);
    // about one response in four sees back-pressure
    stall = (main_rng[1:0] == 2'd0) ? 1 + int'(main_rng[5:4]) : 0;
    req.op   = op;
    req.addr = addr;
    req.data = data;
    cachereq      <= req;
    cachereq_val  <= 1'b1;
    cacheresp_rdy <= (stall == 0);
    do @(posedge clk); while (!cachereq_rdy);
    cachereq_val <= 1'b0;
    // count edges from acceptance to the first valid response
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      compare_value("cachereq_rdy", cachereq_rdy, 1'b0);
    end while (!cacheresp_val);
    if (expect_fast) compare_value("response latency", cycles, 3);
    held = cacheresp;
    if (stall > 0) begin
      repeat (stall) begin
        @(posedge clk);
        compare_value("cacheresp_val", cacheresp_val, 1'b1);
        compare_value("cacheresp", cacheresp, held);
        compare_value("cachereq_rdy", cachereq_rdy, 1'b0);
      end
      cacheresp_rdy <= 1'b1;
      @(posedge clk);
      compare_value("cacheresp_val", cacheresp_val, 1'b1);
      compare_value("cacheresp", cacheresp, held);
    end
    compare_value("cacheresp.op", held.op, expected.op);
    compare_value("cacheresp.hit", held.hit, expected.hit);
    compare_value("cacheresp.data", held.data, expected.data);
    compare_value("missing memory requests", expected_mem.size(), 0);
  endtask

  // ==============================
  // memory model
  // ==============================

  task automatic serve_memory_request();
    mem_msg_pkg::mem_req_t held;
    mem_msg_pkg::mem_req_t expected;
    logic [127:0]          fill;
    held = memreq;
    mem_rng = xorshift(mem_rng);
    repeat (int'(mem_rng[1:0])) begin
      @(posedge clk);
      compare_value("memreq_val", memreq_val, 1'b1);
      compare_value("memreq", memreq, held);
    end
    memreq_rdy <= 1'b1;
    @(posedge clk);
    compare_value("memreq_val", memreq_val, 1'b1);
    compare_value("memreq", memreq, held);
    memreq_rdy <= 1'b0;
    if (expected_mem.size() == 0) abort_run("memory request that the model did not expect");
    expected = expected_mem.pop_front();
    compare_value("memreq.op", held.op, expected.op);
    compare_value("memreq.addr", held.addr, expected.addr);
    fill = '0;
    if (held.op == mem_msg_pkg::op_write) begin
      compare_value("memreq.data", held.data, expected.data);
      for (int k = 0; k < 4; k++) backing_mem[held.addr + 4 * k] = held.data[k * 32 +: 32];
    end else begin
      for (int k = 0; k < 4; k++) fill[k * 32 +: 32] = backing_word(held.addr + 4 * k);
    end
    repeat (int'(mem_rng[5:4])) @(posedge clk);
    memresp.op   <= held.op;
    memresp.data <= fill;
    memresp_val  <= 1'b1;
    do @(posedge clk); while (!memresp_rdy);
    memresp_val <= 1'b0;
  endtask

  initial begin : memory_model
    memreq_rdy  = 1'b0;
    memresp     = '0;
    memresp_val = 1'b0;
    mem_rng     = seed ^ 32'h3c3c_0f0f;
    forever begin
      @(posedge clk);
      // the cache only takes a memory response while it waits for one
      if (!reset) compare_value("memresp_rdy", memresp_rdy, 1'b0);
      if (!reset && memreq_val === 1'b1) serve_memory_request();
    end
  end

  initial begin : watchdog
    #(watchdog_ns);
    abort_run("timeout: the cache stopped answering requests");
  end

  // ==============================
  // main sequence
  // ==============================
  initial begin : main_sequence
    logic [31:0] r;
    mem_msg_pkg::mem_op_e op;
    reset         = 1'b1;
    cachereq      = '0;
    cachereq_val  = 1'b0;
    cacheresp_rdy = 1'b0;
    main_rng      = seed;
    ref_valid     = '0;
    ref_dirty     = '0;
    for (int i = 0; i < `CACHE_NUM_LINES; i++) ref_tag[i] = '0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;

    // init a line, then read all four words back
    run_request(mem_msg_pkg::op_init, 32'h0000_1010, 32'h1111_2222);
    for (int w = 0; w < 4; w++) run_request(mem_msg_pkg::op_read, 32'h0000_1010 + 4 * w, '0);
    // write hit and write miss, each read back
    run_request(mem_msg_pkg::op_write, 32'h0000_1018, 32'hcafe_0001);
    run_request(mem_msg_pkg::op_read, 32'h0000_1018, '0);
    run_request(mem_msg_pkg::op_write, 32'h0000_1054, 32'hbeef_0002);
    run_request(mem_msg_pkg::op_read, 32'h0000_1054, '0);
    // conflict on the dirty line forces a write-back before the refill
    run_request(mem_msg_pkg::op_read, 32'h0004_a218, '0);
    run_request(mem_msg_pkg::op_write, 32'h0004_a21c, 32'h0bad_f00d);
    run_request(mem_msg_pkg::op_read, 32'h0000_1018, '0);
    run_request(mem_msg_pkg::op_read, 32'h0004_a21c, '0);

    // long random mix, init kept rare so lines stay dirty for a while
    for (int i = 0; i < num_random; i++) begin
      main_rng = xorshift(main_rng);
      r = main_rng;
      if (r[14:12] == 3'd0) begin
        op = mem_msg_pkg::op_init;
      end else if (r[14]) begin
        op = mem_msg_pkg::op_read;
      end else begin
        op = mem_msg_pkg::op_write;
      end
      main_rng = xorshift(main_rng);
      run_request(op, pick_addr(r), main_rng);
    end

    repeat (2) @(posedge clk);
    $display("** PASS **");
    $finish;
  end

endmodule

//--- files.f
+incdir+rtl
rtl/mem_msg_pkg.sv
rtl/cache_pkg.sv
rtl/cache_req_in.sv
rtl/cache_ctrl.sv
rtl/cache_store.sv
rtl/cache_resp_out.sv
rtl/blocking_cache.sv
test/cache_tb.sv

//--- run.sh
#!/bin/sh
# builds the cache testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module cache_tb -f files.f -o cache_sim

# the simulator may exit non-zero on a failure, so keep its status out of set -e
./obj_dir/cache_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^\*\* PASS \*\*$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi
